// ==== flist.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/rvfi_pkg.sv
rtl/rvfi_insn_track.sv
rtl/rvfi_data_track.sv
rtl/rvfi_retire.sv
rtl/rvfi_tracer.sv
sim/rvfi_tracer_sva.sv
sim/rvfi_checker.sv
sim/rvfi_tb.sv

// ==== sim/rvfi_tb.sv ====
`timescale 1ns/100ps

module rvfi_tb;

    import core_pkg::*;
    import rvfi_pkg::*;

    localparam int          NUM_ROWS    = 20;
    localparam int          DRIVE_LIMIT = 200;
    localparam int          DRAIN_LIMIT = 50;
    localparam logic [31:0] PC_BASE     = 32'h0000_1000;

    typedef enum logic [4:0] {
        K_ALU, K_ALU_IMM, K_AUIPC, K_JAL, K_JALR, K_BR_TAKEN, K_BR_NOT, K_STORE,
        K_LOAD, K_ALU_X0, K_CSR_W, K_CSR_R, K_CSR_S, K_CSR_C, K_FLUSHED, K_TRAP,
        K_INTR, K_STALL
    } row_kind_t;

    typedef struct packed {
        id_obs_t      id;
        ex_obs_t      ex;
        mem_obs_t     mem;
        wb_obs_t      wb;
        next_pc_mux_t npc;
        logic         flush;
        logic         stall;
    } row_t;

    // Trap rows keep clear of taken branches and of the stall row
    row_kind_t kinds [NUM_ROWS] = '{
        K_ALU, K_ALU_IMM, K_AUIPC, K_JAL, K_JALR, K_BR_TAKEN, K_BR_NOT, K_STORE,
        K_LOAD, K_ALU_X0, K_CSR_W, K_CSR_R, K_CSR_S, K_FLUSHED, K_ALU, K_TRAP,
        K_INTR, K_ALU, K_STALL, K_CSR_C
    };

    row_t        tbl [NUM_ROWS];
    logic [31:0] lcg_state;
    logic        clk;
    logic        rst_n;
    stage_ctrl_t ctrl_if, ctrl_id, ctrl_ex, ctrl_mem, ctrl_wb;
    if_obs_t     if_obs;
    id_obs_t     id_obs;
    ex_obs_t     ex_obs;
    mem_obs_t    mem_obs;
    wb_obs_t     wb_obs;
    rvfi_rec_t   rvfi;

    rvfi_tracer dut0 (
        .clk_i (clk), .rst_n_i (rst_n),
        .ctrl_if_i (ctrl_if), .ctrl_id_i (ctrl_id), .ctrl_ex_i (ctrl_ex),
        .ctrl_mem_i (ctrl_mem), .ctrl_wb_i (ctrl_wb),
        .if_i (if_obs), .id_i (id_obs), .ex_i (ex_obs), .mem_i (mem_obs), .wb_i (wb_obs),
        .rvfi_o (rvfi)
    );

    rvfi_checker chk0 (.clk_i (clk), .rst_n_i (rst_n), .rvfi_i (rvfi));

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic reg_addr_t rand_reg();
        logic [31:0] v;
        v = lcg_next();
        return v[4:0];
    endfunction

    function automatic row_t make_row(input row_kind_t kind, input int idx);
        row_t r;
        r                = '0;
        r.id.instr       = lcg_next();
        r.id.pc          = PC_BASE + 32'(4 * idx);
        r.id.rs1_addr    = rand_reg();
        r.id.rs2_addr    = rand_reg();
        r.id.rs1_rdata   = lcg_next();
        r.id.rs2_rdata   = lcg_next();
        r.wb.rd_addr     = rand_reg() | 5'd1;
        r.wb.reg_wen     = 1'b1;
        r.wb.reg_wdata   = lcg_next();
        case (kind)
            K_ALU_IMM, K_CSR_W, K_CSR_R, K_CSR_S, K_CSR_C: r.id.alu_src2 = ALU_SRC2_IMM;
            K_AUIPC, K_JAL, K_JALR: begin
                r.id.alu_src1    = ALU_SRC1_PC;
                r.id.alu_src2    = ALU_SRC2_IMM;
                r.id.pc_source   = (kind == K_JAL) ? PC_JAL :
                                   (kind == K_JALR) ? PC_JALR : PC_SEQ;
                r.id.jump_target = lcg_next() & 32'hffff_fffc;
            end
            K_BR_TAKEN, K_BR_NOT: begin
                r.id.pc_source        = PC_BRANCH;
                r.ex.branch_target    = lcg_next() & 32'hffff_fffc;
                r.ex.branch_decision  = (kind == K_BR_TAKEN);
                r.wb.reg_wen          = 1'b0;
            end
            K_STORE, K_LOAD: begin
                r.id.alu_src2  = ALU_SRC2_IMM;
                r.id.mem_wen   = (kind == K_STORE);
                r.mem.addr     = lcg_next();
                r.mem.wdata    = (kind == K_STORE) ? lcg_next() : '0;
                r.mem.wen      = (kind == K_STORE);
                r.mem.ben      = (kind == K_STORE) ? 4'b0011 : 4'b1111;
                r.wb.reg_wen   = (kind == K_LOAD);
                r.wb.mem_rdata = (kind == K_LOAD) ? lcg_next() : '0;
            end
            K_ALU_X0:   r.wb.rd_addr = '0;
            K_FLUSHED:  r.flush = 1'b1;
            K_TRAP: begin
                r.id.trap    = 1'b1;
                r.wb.reg_wen = 1'b0;
            end
            K_INTR:     r.npc = NPC_EXCEPTION;
            K_STALL:    r.stall = 1'b1;
            default: ;
        endcase
        if (kind inside {K_CSR_W, K_CSR_R, K_CSR_S, K_CSR_C}) begin
            r.ex.csr_op    = (kind == K_CSR_W) ? CSR_WRITE : (kind == K_CSR_S) ? CSR_SET :
                             (kind == K_CSR_C) ? CSR_CLEAR : CSR_READ;
            r.ex.csr_rdata = lcg_next();
            r.ex.csr_wdata = lcg_next();
        end
        return r;
    endfunction

    function automatic logic in_table(input int s);
        return (s >= 0) && (s < NUM_ROWS);
    endfunction

    function automatic logic live(input int s);
        return in_table(s) && !tbl[s].flush;
    endfunction

    function automatic logic flushed(input int s);
        return in_table(s) && tbl[s].flush;
    endfunction

    // Each stage port shows the row that sits in that stage
    task automatic drive_slots(input int ifs, input int ids, input int exs, input int mems,
                               input int wbs, input logic stall);
        ctrl_if        = '0;
        ctrl_id        = '0;
        ctrl_ex        = '0;
        ctrl_mem       = '0;
        ctrl_wb        = '0;
        ctrl_if.valid  = live(ifs);
        ctrl_id.valid  = live(ids);
        ctrl_ex.valid  = live(exs);
        ctrl_mem.valid = live(mems) && !stall;
        ctrl_wb.valid  = live(wbs);
        ctrl_if.stall  = stall;
        ctrl_id.stall  = stall;
        ctrl_ex.stall  = stall;
        ctrl_mem.stall = stall;
        ctrl_ex.flush  = flushed(ids);
        ctrl_mem.flush = flushed(exs);
        ctrl_wb.flush  = flushed(mems);
        if_obs.pc          = PC_BASE + 32'(4 * ifs);
        if_obs.next_pc_mux = in_table(ifs) ? tbl[ifs].npc : NPC_SEQ;
        id_obs  = in_table(ids) ? tbl[ids].id : '0;
        ex_obs  = in_table(exs) ? tbl[exs].ex : '0;
        mem_obs = in_table(mems) ? tbl[mems].mem : '0;
        wb_obs  = in_table(wbs) ? tbl[wbs].wb : '0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        int   nxt;
        int   ids;
        int   exs;
        int   mems;
        int   wbs;
        int   cycles;
        logic stall_now;
        rst_n     = 1'b0;
        lcg_state = 32'd89;
        nxt       = 0;
        ids       = -1;
        exs       = -1;
        mems      = -1;
        wbs       = -1;
        cycles    = 0;
        stall_now = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            tbl[i] = make_row(kinds[i], i);
        end
        drive_slots(NUM_ROWS, -1, -1, -1, -1, 1'b0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (!tbl[i].flush) begin
                chk0.add_expected(tbl[i].id, tbl[i].ex, tbl[i].mem, tbl[i].wb,
                                  PC_BASE + 32'(4 * (i + 1)), tbl[i].npc == NPC_EXCEPTION);
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        drive_slots(0, -1, -1, -1, -1, 1'b0);

        ////////////////////////////////////////////////////////////
        // Shift rows through ID, EX, MEM and WB
        ////////////////////////////////////////////////////////////
        while ((nxt < NUM_ROWS || ids >= 0 || exs >= 0 || mems >= 0 || wbs >= 0)
               && cycles < DRIVE_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (stall_now) begin
                // Frozen stages release, WB sees a bubble
                wbs       = -1;
                stall_now = 1'b0;
            end else begin
                wbs  = mems;
                mems = exs;
                exs  = ids;
                ids  = (nxt < NUM_ROWS) ? nxt : -1;
                if (nxt < NUM_ROWS) begin
                    nxt++;
                end
                stall_now = in_table(ids) && tbl[ids].stall;
            end
            drive_slots((ids >= 0) ? ids + 1 : nxt, ids, exs, mems, wbs, stall_now);
        end
        if (cycles >= DRIVE_LIMIT) begin
            chk0.note_failure("stimulus loop did not finish in time");
        end

        cycles = 0;
        while (chk0.pending() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (chk0.pending() != 0) begin
            chk0.note_failure("timed out waiting for outstanding retirements");
        end
        // Idle cycles catch any late extra record
        repeat (4) @(negedge clk);
        chk0.report();
        if (chk0.error_total() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/rvfi_checker.sv ====
`timescale 1ns/100ps

module rvfi_checker (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  rvfi_pkg::rvfi_rec_t rvfi_i
);

    import core_pkg::*;
    import rvfi_pkg::*;

    rvfi_rec_t exp_q[$];
    rvfi_rec_t exp_rec;
    order_t    next_order = '0;
    int        value_errs = 0;
    int        other_errs = 0;
    int        checked    = 0;

    // Expected record from the stage values of one instruction
    task automatic add_expected(input id_obs_t id, input ex_obs_t ex, input mem_obs_t mem,
                                input wb_obs_t wb, input word_t seq_pc, input logic intr);
        rvfi_rec_t r;
        r           = '0;
        r.valid     = 1'b1;
        r.order     = next_order;
        r.insn      = id.instr;
        r.trap      = id.trap;
        r.intr      = intr;
        if ((id.alu_src1 == ALU_SRC1_RS1) || (id.pc_source == PC_JALR)) begin
            r.rs1_addr  = id.rs1_addr;
            r.rs1_rdata = id.rs1_rdata;
        end
        if ((id.alu_src2 == ALU_SRC2_RS2) || id.mem_wen) begin
            r.rs2_addr  = id.rs2_addr;
            r.rs2_rdata = id.rs2_rdata;
        end
        r.rd_addr   = wb.reg_wen ? wb.rd_addr : '0;
        r.rd_wdata  = (r.rd_addr == '0) ? '0 : wb.reg_wdata;
        r.pc_rdata  = id.pc;
        r.pc_wdata  = (id.pc_source inside {PC_JAL, PC_JALR}) ? id.jump_target : seq_pc;
        if (ex.branch_decision) begin
            r.pc_wdata = ex.branch_target;
        end
        r.mem_addr  = mem.addr;
        r.mem_rmask = mem.ben;
        r.mem_wmask = mem.wen ? mem.ben : '0;
        r.mem_wdata = mem.wdata;
        r.mem_rdata = wb.mem_rdata;
        r.csr_rmask = '1;
        r.csr_rdata = ex.csr_rdata;
        r.csr_wmask = (ex.csr_op != CSR_READ) ? '1 : '0;
        r.csr_wdata = ex.csr_wdata;
        exp_q.push_back(r);
        next_order++;
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic int error_total();
        return value_errs + other_errs;
    endfunction

    task automatic note_failure(input string what);
        other_errs++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic cmp_field(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            value_errs++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic compare_record(input rvfi_rec_t e);
        cmp_field("order", e.order, rvfi_i.order);
        cmp_field("insn", e.insn, rvfi_i.insn);
        cmp_field("trap", e.trap, rvfi_i.trap);
        cmp_field("intr", e.intr, rvfi_i.intr);
        cmp_field("rs1_addr", e.rs1_addr, rvfi_i.rs1_addr);
        cmp_field("rs2_addr", e.rs2_addr, rvfi_i.rs2_addr);
        cmp_field("rs1_rdata", e.rs1_rdata, rvfi_i.rs1_rdata);
        cmp_field("rs2_rdata", e.rs2_rdata, rvfi_i.rs2_rdata);
        cmp_field("rd_addr", e.rd_addr, rvfi_i.rd_addr);
        cmp_field("rd_wdata", e.rd_wdata, rvfi_i.rd_wdata);
        cmp_field("pc_rdata", e.pc_rdata, rvfi_i.pc_rdata);
        cmp_field("pc_wdata", e.pc_wdata, rvfi_i.pc_wdata);
        cmp_field("mem_addr", e.mem_addr, rvfi_i.mem_addr);
        cmp_field("mem_rmask", e.mem_rmask, rvfi_i.mem_rmask);
        cmp_field("mem_rdata", e.mem_rdata, rvfi_i.mem_rdata);
        cmp_field("mem_wmask", e.mem_wmask, rvfi_i.mem_wmask);
        cmp_field("mem_wdata", e.mem_wdata, rvfi_i.mem_wdata);
        cmp_field("csr_rmask", e.csr_rmask, rvfi_i.csr_rmask);
        cmp_field("csr_rdata", e.csr_rdata, rvfi_i.csr_rdata);
        cmp_field("csr_wmask", e.csr_wmask, rvfi_i.csr_wmask);
        cmp_field("csr_wdata", e.csr_wdata, rvfi_i.csr_wdata);
    endtask

    // Record is stable from the falling edge, sample on the rising one
    always @(posedge clk_i) begin
        if (rst_n_i && rvfi_i.valid) begin
            if (exp_q.size() == 0) begin
                note_failure("retirement seen while no instruction was expected");
            end else begin
                exp_rec = exp_q.pop_front();
                compare_record(exp_rec);
                checked++;
            end
        end
    end

    task automatic report();
        $display("Checked %0d records, %0d value errors, %0d other errors",
                 checked, value_errs, other_errs);
    endtask

endmodule

// ==== sim/rvfi_tracer_sva.sv ====
`timescale 1ns/100ps

module rvfi_tracer_sva (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  rvfi_pkg::rvfi_rec_t rvfi_i
);

    import rvfi_pkg::*;

    // Nothing retires in the first cycle out of reset
    idle_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !rvfi_i.valid && (rvfi_i.order == '0))
        else $error("record valid or order nonzero right after reset");

    order_monotonic: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) |-> rvfi_i.order >= $past(rvfi_i.order))
        else $error("order counter went backwards");

    // One step per retirement
    order_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) && $past(rvfi_i.valid) |-> rvfi_i.order == $past(rvfi_i.order) + 1)
        else $error("order counter did not advance after a retirement");

    x0_write_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvfi_i.rd_addr == '0 |-> rvfi_i.rd_wdata == '0)
        else $error("nonzero rd_wdata reported for x0");

endmodule

bind rvfi_tracer rvfi_tracer_sva sva0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rvfi_i  (rvfi_o)
);

// ==== rtl/rvfi_tracer.sv ====
`timescale 1ns/100ps

module rvfi_tracer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  core_pkg::stage_ctrl_t ctrl_if_i,
    input  core_pkg::stage_ctrl_t ctrl_id_i,
    input  core_pkg::stage_ctrl_t ctrl_ex_i,
    input  core_pkg::stage_ctrl_t ctrl_mem_i,
    input  core_pkg::stage_ctrl_t ctrl_wb_i,
    input  core_pkg::if_obs_t     if_i,
    input  core_pkg::id_obs_t     id_i,
    input  core_pkg::ex_obs_t     ex_i,
    input  core_pkg::mem_obs_t    mem_i,
    input  core_pkg::wb_obs_t     wb_i,
    output rvfi_pkg::rvfi_rec_t   rvfi_o
);

    import rvfi_pkg::*;

    insn_trace_t insn_wb;
    logic        valid_insn_wb;
    data_trace_t data_wb;

    // Instruction, operand and PC shadow pipeline
    rvfi_insn_track insn0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ctrl_if_i  (ctrl_if_i),
        .ctrl_id_i  (ctrl_id_i),
        .ctrl_ex_i  (ctrl_ex_i),
        .ctrl_mem_i (ctrl_mem_i),
        .ctrl_wb_i  (ctrl_wb_i),
        .if_i       (if_i),
        .id_i       (id_i),
        .ex_i       (ex_i),
        .insn_wb_o  (insn_wb),
        .valid_wb_o (valid_insn_wb)
    );

    // CSR and data memory capture
    rvfi_data_track data0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ctrl_ex_i  (ctrl_ex_i),
        .ctrl_mem_i (ctrl_mem_i),
        .ctrl_wb_i  (ctrl_wb_i),
        .ex_i       (ex_i),
        .mem_i      (mem_i),
        .data_wb_o  (data_wb)
    );

    rvfi_retire retire0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .insn_wb_i  (insn_wb),
        .valid_wb_i (valid_insn_wb),
        .data_wb_i  (data_wb),
        .wb_i       (wb_i),
        .rvfi_o     (rvfi_o)
    );

endmodule

// ==== rtl/rvfi_retire.sv ====
`timescale 1ns/100ps
`include "rvfi_cfg.svh"

module rvfi_retire (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rvfi_pkg::insn_trace_t insn_wb_i,
    input  logic                  valid_wb_i,
    input  rvfi_pkg::data_trace_t data_wb_i,
    input  core_pkg::wb_obs_t     wb_i,
    output rvfi_pkg::rvfi_rec_t   rvfi_o
);

    import core_pkg::*;
    import rvfi_pkg::*;

    order_t    order_q;
    logic      retire;
    reg_addr_t rd_addr;

    // Trapped instructions retire even without a valid write-back
    assign retire  = valid_wb_i || insn_wb_i.trap;
    assign rd_addr = wb_i.reg_wen ? wb_i.rd_addr : '0;

    ////////////////////////////////////////////////////////////
    // Order counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            order_q <= '0;
        end else if (retire) begin
            order_q <= order_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Record assembly
    ////////////////////////////////////////////////////////////

    always_comb begin
        rvfi_o           = '0;
        rvfi_o.valid     = retire;
        rvfi_o.order     = order_q;
        rvfi_o.insn      = insn_wb_i.instr;
        rvfi_o.trap      = insn_wb_i.trap;
        rvfi_o.intr      = insn_wb_i.intr;
        rvfi_o.rs1_addr  = insn_wb_i.rs1_addr;
        rvfi_o.rs2_addr  = insn_wb_i.rs2_addr;
        rvfi_o.rs1_rdata = insn_wb_i.rs1_rdata;
        rvfi_o.rs2_rdata = insn_wb_i.rs2_rdata;
        rvfi_o.pc_rdata  = insn_wb_i.pc_rdata;
        rvfi_o.pc_wdata  = insn_wb_i.pc_wdata;

        // x0 always reads back as zero
        rvfi_o.rd_addr   = rd_addr;
        rvfi_o.rd_wdata  = (rd_addr == '0) ? '0 : wb_i.reg_wdata;

        rvfi_o.mem_addr  = data_wb_i.mem_addr;
        rvfi_o.mem_rmask = data_wb_i.mem_rmask;
        rvfi_o.mem_rdata = wb_i.mem_rdata;
        rvfi_o.mem_wmask = data_wb_i.mem_wmask;
        rvfi_o.mem_wdata = data_wb_i.mem_wdata;

        // Whole-register masks on the shared CSR channel
        rvfi_o.csr_rmask = {`RVFI_XLEN{valid_wb_i}};
        rvfi_o.csr_rdata = data_wb_i.csr_rdata;
        rvfi_o.csr_wmask = {`RVFI_XLEN{data_wb_i.csr_wen}};
        rvfi_o.csr_wdata = data_wb_i.csr_wdata;
    end

endmodule

// ==== rtl/rvfi_data_track.sv ====
`timescale 1ns/100ps

module rvfi_data_track (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  core_pkg::stage_ctrl_t ctrl_ex_i,
    input  core_pkg::stage_ctrl_t ctrl_mem_i,
    input  core_pkg::stage_ctrl_t ctrl_wb_i,
    input  core_pkg::ex_obs_t     ex_i,
    input  core_pkg::mem_obs_t    mem_i,
    output rvfi_pkg::data_trace_t data_wb_o
);

    import core_pkg::*;
    import rvfi_pkg::*;

    data_trace_t mem_d, mem_q;
    data_trace_t wb_d, wb_q;

    ////////////////////////////////////////////////////////////
    // EX -> MEM, CSR values only
    ////////////////////////////////////////////////////////////

    always_comb begin
        mem_d = '0;
        if (!ctrl_mem_i.flush) begin
            mem_d.csr_rdata = ex_i.csr_rdata;
            mem_d.csr_wdata = ex_i.csr_wdata;
            // Every CSR op except a plain read modifies the register
            mem_d.csr_wen   = ctrl_ex_i.valid && (ex_i.csr_op != CSR_READ);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_q <= '0;
        end else if (!ctrl_mem_i.stall) begin
            mem_q <= mem_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // MEM -> WB, CSR values plus the data access
    ////////////////////////////////////////////////////////////

    always_comb begin
        wb_d = mem_q;
        wb_d.mem_addr  = mem_i.addr;
        wb_d.mem_wdata = mem_i.wdata;
        wb_d.mem_rmask = mem_i.ben;
        wb_d.mem_wmask = mem_i.wen ? mem_i.ben : '0;
        if (ctrl_wb_i.flush) begin
            wb_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_d;
        end
    end

    assign data_wb_o = wb_q;

endmodule

// ==== rtl/rvfi_insn_track.sv ====
`timescale 1ns/100ps

module rvfi_insn_track (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  core_pkg::stage_ctrl_t ctrl_if_i,
    input  core_pkg::stage_ctrl_t ctrl_id_i,
    input  core_pkg::stage_ctrl_t ctrl_ex_i,
    input  core_pkg::stage_ctrl_t ctrl_mem_i,
    input  core_pkg::stage_ctrl_t ctrl_wb_i,
    input  core_pkg::if_obs_t     if_i,
    input  core_pkg::id_obs_t     id_i,
    input  core_pkg::ex_obs_t     ex_i,
    output rvfi_pkg::insn_trace_t insn_wb_o,
    output logic                  valid_wb_o
);

    import core_pkg::*;
    import rvfi_pkg::*;

    logic        intr_id;
    logic        rs1_used;
    logic        rs2_used;
    insn_trace_t ex_d, ex_q;
    insn_trace_t mem_d, mem_q;
    insn_trace_t wb_d, wb_q;
    logic        valid_wb_q;

    ////////////////////////////////////////////////////////////
    // IF -> ID
    ////////////////////////////////////////////////////////////

    // Fetch redirected to the trap vector marks the fetched instruction
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            intr_id <= 1'b0;
        end else if (!ctrl_id_i.stall) begin
            if (ctrl_id_i.flush) begin
                intr_id <= 1'b0;
            end else begin
                intr_id <= ctrl_if_i.valid && (if_i.next_pc_mux == NPC_EXCEPTION);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // ID -> EX
    ////////////////////////////////////////////////////////////

    // Report only the operands the instruction actually reads
    assign rs1_used = (id_i.alu_src1 == ALU_SRC1_RS1) || (id_i.pc_source == PC_JALR);
    assign rs2_used = (id_i.alu_src2 == ALU_SRC2_RS2) || id_i.mem_wen;

    always_comb begin
        ex_d          = '0;
        ex_d.instr    = id_i.instr;
        ex_d.pc_rdata = id_i.pc;
        if (rs1_used) begin
            ex_d.rs1_addr  = id_i.rs1_addr;
            ex_d.rs1_rdata = id_i.rs1_rdata;
        end
        if (rs2_used) begin
            ex_d.rs2_addr  = id_i.rs2_addr;
            ex_d.rs2_rdata = id_i.rs2_rdata;
        end
        if (!ctrl_ex_i.flush) begin
            // A taken branch in EX squashes the decode trap
            ex_d.trap = id_i.trap && !ctrl_id_i.stall && !ex_i.branch_decision;
            ex_d.intr = intr_id;
            if (id_i.pc_source inside {PC_JAL, PC_JALR}) begin
                ex_d.pc_wdata = id_i.jump_target;
            end else begin
                ex_d.pc_wdata = if_i.pc;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_q <= '0;
        end else if (!ctrl_ex_i.stall) begin
            ex_q <= ex_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // EX -> MEM
    ////////////////////////////////////////////////////////////

    always_comb begin
        mem_d = ex_q;
        if (ctrl_mem_i.flush) begin
            mem_d.trap     = 1'b0;
            mem_d.intr     = 1'b0;
            mem_d.pc_wdata = '0;
        end else begin
            mem_d.trap = ex_q.trap || (ex_i.trap && !ctrl_ex_i.stall);
            // Branch outcome overrides the sequential next PC
            if (ex_i.branch_decision) begin
                mem_d.pc_wdata = ex_i.branch_target;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_q <= '0;
        end else if (!ctrl_mem_i.stall) begin
            mem_q <= mem_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // MEM -> WB
    ////////////////////////////////////////////////////////////

    always_comb begin
        wb_d = mem_q;
        if (ctrl_wb_i.flush) begin
            wb_d.trap     = 1'b0;
            wb_d.intr     = 1'b0;
            wb_d.pc_wdata = '0;
        end
    end

    // WB never stalls
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q       <= '0;
            valid_wb_q <= 1'b0;
        end else begin
            wb_q       <= wb_d;
            valid_wb_q <= ctrl_mem_i.valid && !ctrl_wb_i.flush;
        end
    end

    assign insn_wb_o  = wb_q;
    assign valid_wb_o = valid_wb_q;

endmodule

// ==== rtl/rvfi_pkg.sv ====
`include "rvfi_cfg.svh"

package rvfi_pkg;

    typedef logic [`RVFI_ORDER_W-1:0] order_t;

    // Instruction side of a retiring entry
    typedef struct packed {
        core_pkg::word_t     instr;
        logic                trap;
        logic                intr;
        core_pkg::reg_addr_t rs1_addr;
        core_pkg::reg_addr_t rs2_addr;
        core_pkg::word_t     rs1_rdata;
        core_pkg::word_t     rs2_rdata;
        core_pkg::word_t     pc_rdata;
        core_pkg::word_t     pc_wdata;
    } insn_trace_t;

    // Data memory and CSR side of a retiring entry
    typedef struct packed {
        core_pkg::word_t mem_addr;
        core_pkg::ben_t  mem_rmask;
        core_pkg::ben_t  mem_wmask;
        core_pkg::word_t mem_wdata;
        core_pkg::word_t csr_rdata;
        core_pkg::word_t csr_wdata;
        logic            csr_wen;
    } data_trace_t;

    ////////////////////////////////////////////////////////////
    // Retirement record, RVFI field set
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                valid;
        order_t              order;
        core_pkg::word_t     insn;
        logic                trap;
        logic                intr;
        core_pkg::reg_addr_t rs1_addr;
        core_pkg::reg_addr_t rs2_addr;
        core_pkg::word_t     rs1_rdata;
        core_pkg::word_t     rs2_rdata;
        core_pkg::reg_addr_t rd_addr;
        core_pkg::word_t     rd_wdata;
        core_pkg::word_t     pc_rdata;
        core_pkg::word_t     pc_wdata;
        core_pkg::word_t     mem_addr;
        core_pkg::ben_t      mem_rmask;
        core_pkg::word_t     mem_rdata;
        core_pkg::ben_t      mem_wmask;
        core_pkg::word_t     mem_wdata;
        // Shared channel for the named CSRs
        core_pkg::word_t     csr_rmask;
        core_pkg::word_t     csr_rdata;
        core_pkg::word_t     csr_wmask;
        core_pkg::word_t     csr_wdata;
    } rvfi_rec_t;

endpackage

// ==== rtl/core_pkg.sv ====
`include "rvfi_cfg.svh"

package core_pkg;

    typedef logic [`RVFI_XLEN-1:0]   word_t;
    typedef logic [`RVFI_REG_AW-1:0] reg_addr_t;
    typedef logic [`RVFI_BEN_W-1:0]  ben_t;

    ////////////////////////////////////////////////////////////
    // Core control encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        NPC_SEQ       = 2'b00,
        NPC_JUMP      = 2'b01,
        NPC_BRANCH    = 2'b10,
        NPC_EXCEPTION = 2'b11
    } next_pc_mux_t;

    typedef enum logic [1:0] {
        ALU_SRC1_RS1  = 2'b00,
        ALU_SRC1_PC   = 2'b01,
        ALU_SRC1_ZERO = 2'b10
    } alu_src1_t;

    typedef enum logic {
        ALU_SRC2_RS2 = 1'b0,
        ALU_SRC2_IMM = 1'b1
    } alu_src2_t;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'b00,
        PC_JAL    = 2'b01,
        PC_JALR   = 2'b10,
        PC_BRANCH = 2'b11
    } pc_source_t;

    typedef enum logic [1:0] {
        CSR_READ  = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_t;

    ////////////////////////////////////////////////////////////
    // Per-stage observation bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic valid;
        logic stall;
        logic flush;
    } stage_ctrl_t;

    typedef struct packed {
        word_t        pc;
        next_pc_mux_t next_pc_mux;
    } if_obs_t;

    typedef struct packed {
        word_t      instr;
        logic       trap;
        reg_addr_t  rs1_addr;
        reg_addr_t  rs2_addr;
        word_t      rs1_rdata;
        word_t      rs2_rdata;
        word_t      pc;
        alu_src1_t  alu_src1;
        alu_src2_t  alu_src2;
        pc_source_t pc_source;
        word_t      jump_target;
        logic       mem_wen;
    } id_obs_t;

    typedef struct packed {
        logic    trap;
        word_t   branch_target;
        logic    branch_decision;
        word_t   csr_wdata;
        word_t   csr_rdata;
        csr_op_t csr_op;
    } ex_obs_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  wen;
        ben_t  ben;
    } mem_obs_t;

    typedef struct packed {
        reg_addr_t rd_addr;
        logic      reg_wen;
        word_t     reg_wdata;
        word_t     mem_rdata;
    } wb_obs_t;

endpackage

// ==== rtl/rvfi_cfg.svh ====
`ifndef RVFI_CFG_SVH
`define RVFI_CFG_SVH

// RV32 data and PC width
`define RVFI_XLEN 32

// Integer register index
`define RVFI_REG_AW 5

// Retirement order counter
`define RVFI_ORDER_W 64

// One enable bit per data byte
`define RVFI_BEN_W 4

`endif
